// File: m16Pkg.sv
`default_nettype none

package m16Pkg;

	parameter int byteW = 8; // serial data byte
	parameter int orbWordW = 12; // telemetry word
	parameter int chanW = 3; // channel index, up to 8
	parameter int idxW = 3; // byte position in a packet
	parameter int frameAddrW = 6; // frame memory, up to 64 words

	parameter logic [orbWordW-1:0] syncWord = 12'hF5A; // word 0 of every frame

	// one byte read back out of a channel buffer
	typedef struct packed {
		logic strobe; // byte valid this cycle
		logic [chanW-1:0] chan; // source channel
		logic [idxW-1:0] byteIdx; // position within packet
		logic [byteW-1:0] data;
	} chanRead_t;

	// one write into the frame memory
	typedef struct packed {
		logic wrEn;
		logic [frameAddrW-1:0] addr; // fixed slot in frame
		logic [orbWordW-1:0] word; // tagged telemetry word
	} orbWrite_t;

endpackage

`default_nettype wire

// File: uartRx.sv
`default_nettype none

module uartRx #(
	parameter int clksPerBit = 694
) (
	input logic clk80MHz,
	input logic rstN,
	input logic rx, // serial line, idle high
	output logic [m16Pkg::byteW-1:0] rxByte,
	output logic byteValid
);

	localparam int bW = m16Pkg::byteW;
	localparam int cntW = $clog2(clksPerBit + 1);
	localparam logic [cntW-1:0] lastCnt = cntW'(clksPerBit - 1); // one full bit
	localparam logic [cntW-1:0] halfCnt = cntW'(clksPerBit / 2 - 1); // to mid start bit

	typedef enum logic [1:0] {
		idle,
		startBit,
		dataBits,
		stopBit
	} state_t;

	state_t state;
	logic [1:0] rxSync; // two-flop synchronizer
	logic [cntW-1:0] bitCnt; // clocks inside current bit
	logic [2:0] bitIdx; // data bit number
	logic [bW-1:0] shiftReg; // lsb arrives first

	always_ff @(posedge clk80MHz) begin
		if (!rstN) begin
			rxSync <= 2'b11; // line idles high
		end else begin
			rxSync <= {rxSync[0], rx};
		end
	end

	always_ff @(posedge clk80MHz) begin
		if (!rstN) begin
			state <= idle;
			bitCnt <= '0;
			bitIdx <= '0;
			byteValid <= 1'b0;
		end else begin
			byteValid <= 1'b0; // single-cycle strobe
			case (state)
				idle: begin
					bitCnt <= '0;
					if (!rxSync[1]) begin
						state <= startBit; // start edge seen
					end
				end
				startBit: begin
					if (bitCnt == halfCnt) begin
						bitCnt <= '0;
						bitIdx <= '0;
						state <= rxSync[1] ? idle : dataBits; // high again means glitch
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
				dataBits: begin
					if (bitCnt == lastCnt) begin
						bitCnt <= '0;
						shiftReg <= {rxSync[1], shiftReg[bW-1:1]}; // mid-bit sample
						bitIdx <= bitIdx + 1'b1;
						if (bitIdx == 3'd7) begin
							state <= stopBit;
						end
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
				default: begin // stop bit
					if (bitCnt == lastCnt) begin
						bitCnt <= '0;
						state <= idle;
						if (rxSync[1]) begin
							byteValid <= 1'b1; // framing ok
							rxByte <= shiftReg;
						end
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: chanBuffer.sv
`default_nettype none

module chanBuffer #(
	parameter int packetBytes = 4
) (
	input logic clk80MHz,
	input logic rstN,
	input logic [m16Pkg::byteW-1:0] rxByte,
	input logic byteValid,
	input logic rdEn,
	input logic [m16Pkg::idxW-1:0] rdAddr,
	output logic [m16Pkg::byteW-1:0] rdData,
	output logic full // one pulse per finished packet
);

	localparam int bW = m16Pkg::byteW;
	localparam int iW = m16Pkg::idxW;
	localparam logic [iW-1:0] lastIdx = iW'(packetBytes - 1);

	logic [bW-1:0] mem [2**iW]; // sized to the index range
	logic [iW-1:0] wrCnt; // next byte slot
	logic wrEn; // byteValid delayed one cycle
	logic [bW-1:0] wrData;

	always_ff @(posedge clk80MHz) begin
		if (!rstN) begin
			wrEn <= 1'b0;
			wrCnt <= '0;
			full <= 1'b0;
		end else begin
			wrEn <= byteValid;
			full <= 1'b0;
			if (wrEn) begin
				if (wrCnt == lastIdx) begin
					wrCnt <= '0; // wrap for next packet
					full <= 1'b1;
				end else begin
					wrCnt <= wrCnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk80MHz) begin
		wrData <= rxByte;
		if (wrEn) begin
			mem[wrCnt] <= wrData;
		end
		if (rdEn) begin
			rdData <= mem[rdAddr]; // one cycle read latency
		end
	end

endmodule

`default_nettype wire

// File: rdScheduler.sv
`default_nettype none

module rdScheduler #(
	parameter int numChan = 3,
	parameter int packetBytes = 4
) (
	input logic clk80MHz,
	input logic rstN,
	input logic [numChan-1:0] full,
	input logic [numChan*m16Pkg::byteW-1:0] rdData,
	output logic [numChan-1:0] rdEn,
	output logic [m16Pkg::idxW-1:0] rdAddr,
	output m16Pkg::chanRead_t rd
);

	localparam int bW = m16Pkg::byteW;
	localparam int cW = m16Pkg::chanW;
	localparam int iW = m16Pkg::idxW;
	localparam logic [iW-1:0] lastIdx = iW'(packetBytes - 1);

	logic [numChan-1:0] pending; // packets waiting for readout
	logic [numChan-1:0] grant; // lowest pending, one-hot
	logic [cW-1:0] pickChan;
	logic pickValid;
	logic busy;
	logic [cW-1:0] curChan; // channel being read
	logic [iW-1:0] rdIdx;
	logic strobeQ; // memory data valid
	logic [cW-1:0] chanQ;
	logic [iW-1:0] idxQ;

	always_comb begin
		pickValid = 1'b0;
		pickChan = '0;
		grant = '0;
		for (int i = numChan - 1; i >= 0; i--) begin // lowest index wins
			if (pending[i]) begin
				pickValid = 1'b1;
				pickChan = cW'(i);
				grant = '0;
				grant[i] = 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < numChan; i++) begin
			rdEn[i] = busy && (curChan == cW'(i));
		end
	end

	assign rdAddr = rdIdx;

	always_ff @(posedge clk80MHz) begin
		if (!rstN) begin
			pending <= '0;
			busy <= 1'b0;
			curChan <= '0;
			rdIdx <= '0;
			strobeQ <= 1'b0;
		end else begin
			pending <= (pending | full) & ~(grant & {numChan{!busy}}); // late pulses stay queued
			strobeQ <= busy;
			if (busy) begin
				rdIdx <= rdIdx + 1'b1;
				if (rdIdx == lastIdx) begin
					busy <= 1'b0; // packet done
				end
			end else if (pickValid) begin
				busy <= 1'b1;
				curChan <= pickChan;
				rdIdx <= '0;
			end
		end
	end

	always_ff @(posedge clk80MHz) begin
		chanQ <= curChan; // tags line up with read data
		idxQ <= rdIdx;
	end

	assign rd.strobe = strobeQ;
	assign rd.chan = chanQ;
	assign rd.byteIdx = idxQ;
	assign rd.data = rdData[chanQ*bW +: bW]; // pick the served channel

endmodule

`default_nettype wire

// File: orbPacker.sv
`default_nettype none

module orbPacker #(
	parameter int packetBytes = 4
) (
	input logic clk80MHz,
	input logic rstN,
	input m16Pkg::chanRead_t rd,
	output m16Pkg::orbWrite_t wr
);

	localparam int aW = m16Pkg::frameAddrW;
	localparam int wW = m16Pkg::orbWordW;
	localparam int tagW = m16Pkg::orbWordW - m16Pkg::byteW; // upper nibble

	logic wrEnQ;
	logic [aW-1:0] addrQ;
	logic [wW-1:0] wordQ;
	logic [tagW-1:0] tag;
	logic [aW-1:0] slot;

	assign tag = tagW'(rd.chan) + tagW'(1); // channel numbers start at 1
	// slot 0 holds sync, channels follow in order
	assign slot = aW'(1) + aW'(rd.chan) * aW'(packetBytes) + aW'(rd.byteIdx);

	always_ff @(posedge clk80MHz) begin
		if (!rstN) begin
			wrEnQ <= 1'b0;
		end else begin
			wrEnQ <= rd.strobe;
		end
	end

	always_ff @(posedge clk80MHz) begin
		addrQ <= slot;
		wordQ <= {tag, rd.data}; // tag above raw byte
	end

	assign wr.wrEn = wrEnQ;
	assign wr.addr = addrQ;
	assign wr.word = wordQ;

endmodule

`default_nettype wire

// File: frameBuffer.sv
`default_nettype none

module frameBuffer (
	input logic clk80MHz,
	input logic rstN,
	input m16Pkg::orbWrite_t wr,
	input logic [m16Pkg::frameAddrW-1:0] rdAddr,
	input logic swap,
	output logic [m16Pkg::orbWordW-1:0] rdData
);

	localparam int aW = m16Pkg::frameAddrW;
	localparam int wW = m16Pkg::orbWordW;

	logic [wW-1:0] mem [2][2**aW]; // ping-pong banks
	logic bankSel; // bank on the read side
	logic [aW-1:0] sweepAddr; // clear pointer

	always_ff @(posedge clk80MHz) begin
		if (!rstN) begin
			bankSel <= 1'b0;
		end else if (swap) begin
			bankSel <= !bankSel; // effective next cycle
		end
	end

	always_ff @(posedge clk80MHz) begin
		if (!rstN) begin
			sweepAddr <= sweepAddr + 1'b1; // walks both banks while held
		end else begin
			sweepAddr <= '0;
		end
	end

	always_ff @(posedge clk80MHz) begin
		if (!rstN) begin
			mem[0][sweepAddr] <= '0;
			mem[1][sweepAddr] <= '0;
		end else if (wr.wrEn) begin
			mem[!bankSel][wr.addr] <= wr.word; // fill the idle bank
		end
	end

	always_ff @(posedge clk80MHz) begin
		rdData <= mem[bankSel][rdAddr]; // read latency one
	end

endmodule

`default_nettype wire

// File: frameReader.sv
`default_nettype none

module frameReader #(
	parameter int numChan = 3,
	parameter int packetBytes = 4,
	parameter int wordDiv = 64
) (
	input logic clk80MHz,
	input logic rstN,
	input logic [m16Pkg::orbWordW-1:0] rdData,
	output logic [m16Pkg::frameAddrW-1:0] rdAddr,
	output logic swap,
	output logic [m16Pkg::orbWordW-1:0] orbWord,
	output logic wordStrobe,
	output logic frameStart
);

	localparam int aW = m16Pkg::frameAddrW;
	localparam int frameWords = numChan * packetBytes + 1; // sync plus data
	localparam int divW = $clog2(wordDiv + 1);
	localparam logic [divW-1:0] lastDiv = divW'(wordDiv - 1);
	localparam logic [aW-1:0] lastWord = aW'(frameWords - 1);

	logic [divW-1:0] divCnt; // word rate divider
	logic [aW-1:0] wordCnt; // position in frame
	logic tick; // issue an address

	assign tick = (divCnt == lastDiv);
	assign rdAddr = wordCnt;
	assign swap = tick && (wordCnt == lastWord); // with the last address
	assign orbWord = frameStart ? m16Pkg::syncWord : rdData; // sync never read from memory

	always_ff @(posedge clk80MHz) begin
		if (!rstN) begin
			divCnt <= '0;
			wordCnt <= '0;
			wordStrobe <= 1'b0;
			frameStart <= 1'b0;
		end else begin
			wordStrobe <= tick; // data back from memory now
			frameStart <= tick && (wordCnt == '0);
			if (tick) begin
				divCnt <= '0;
				if (wordCnt == lastWord) begin
					wordCnt <= '0; // next frame
				end else begin
					wordCnt <= wordCnt + 1'b1;
				end
			end else begin
				divCnt <= divCnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: m16Top.sv
`default_nettype none

module m16Top #(
	parameter int numChan = 3,
	parameter int packetBytes = 4,
	parameter int clksPerBit = 694,
	parameter int wordDiv = 64
) (
	input logic clk80MHz,
	input logic rstN,
	input logic [numChan-1:0] rx, // one serial line per sensor board
	output logic [m16Pkg::orbWordW-1:0] orbWord,
	output logic wordStrobe,
	output logic frameStart
);

	localparam int bW = m16Pkg::byteW;

	logic [numChan-1:0][bW-1:0] rxByte;
	logic [numChan-1:0] byteValid;
	logic [numChan-1:0] full;
	logic [numChan-1:0] rdEn;
	logic [numChan*bW-1:0] chanData; // all buffer outputs side by side
	logic [m16Pkg::idxW-1:0] chanAddr; // shared buffer read address
	m16Pkg::chanRead_t rd;
	m16Pkg::orbWrite_t wr;
	logic [m16Pkg::frameAddrW-1:0] frameAddr;
	logic swap;
	logic [m16Pkg::orbWordW-1:0] frameData;

	for (genvar c = 0; c < numChan; c++) begin : gChan
		uartRx #(
			.clksPerBit(clksPerBit)
		) uartRx_inst (
			.clk80MHz(clk80MHz),
			.rstN(rstN),
			.rx(rx[c]),
			.rxByte(rxByte[c]),
			.byteValid(byteValid[c])
		);

		chanBuffer #(
			.packetBytes(packetBytes)
		) chanBuffer_inst (
			.clk80MHz(clk80MHz),
			.rstN(rstN),
			.rxByte(rxByte[c]),
			.byteValid(byteValid[c]),
			.rdEn(rdEn[c]),
			.rdAddr(chanAddr),
			.rdData(chanData[c*bW +: bW]),
			.full(full[c])
		);
	end

	rdScheduler #(
		.numChan(numChan),
		.packetBytes(packetBytes)
	) rdScheduler_inst (
		.clk80MHz(clk80MHz),
		.rstN(rstN),
		.full(full),
		.rdData(chanData),
		.rdEn(rdEn),
		.rdAddr(chanAddr),
		.rd(rd)
	);

	orbPacker #(
		.packetBytes(packetBytes)
	) orbPacker_inst (
		.clk80MHz(clk80MHz),
		.rstN(rstN),
		.rd(rd),
		.wr(wr)
	);

	frameBuffer frameBuffer_inst (
		.clk80MHz(clk80MHz),
		.rstN(rstN),
		.wr(wr),
		.rdAddr(frameAddr),
		.swap(swap),
		.rdData(frameData)
	);

	frameReader #(
		.numChan(numChan),
		.packetBytes(packetBytes),
		.wordDiv(wordDiv)
	) frameReader_inst (
		.clk80MHz(clk80MHz),
		.rstN(rstN),
		.rdData(frameData),
		.rdAddr(frameAddr),
		.swap(swap),
		.orbWord(orbWord),
		.wordStrobe(wordStrobe),
		.frameStart(frameStart)
	);

endmodule

`default_nettype wire

// File: tbM16.sv
`default_nettype none

module tbM16;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int numChan = 3;
	localparam int packetBytes = 4;
	localparam int clksPerBit = 8; // fast serial for simulation
	localparam int wordDiv = 32;
	localparam int frameWords = numChan * packetBytes + 1; // sync plus data slots
	localparam int numRows = 5;
	localparam int numFrames = numRows + 2; // two quiet frames, last row shows one frame late
	localparam int timeoutCycles = (numRows + 3) * frameWords * wordDiv;
	localparam int tagW = m16Pkg::orbWordW - m16Pkg::byteW;
	localparam int driveDly = 1; // ns after the rising edge

	// one stimulus row, a packet for each enabled channel
	typedef struct packed {
		logic [numChan-1:0] chanMask; // channels that send in this row
		logic [numChan*packetBytes-1:0][m16Pkg::byteW-1:0] bytes; // channel-major
	} row_t;

	logic clk80MHz;
	logic rstN;
	logic [numChan-1:0] rx;
	logic [m16Pkg::orbWordW-1:0] orbWord;
	logic wordStrobe;
	logic frameStart;

	row_t rows [numRows];
	logic [m16Pkg::orbWordW-1:0] bankImg [2][frameWords]; // expected bank contents
	integer seed;
	int cycles;

	m16Top #(
		.numChan(numChan),
		.packetBytes(packetBytes),
		.clksPerBit(clksPerBit),
		.wordDiv(wordDiv)
	) m16Top_inst (
		.clk80MHz(clk80MHz),
		.rstN(rstN),
		.rx(rx),
		.orbWord(orbWord),
		.wordStrobe(wordStrobe),
		.frameStart(frameStart)
	);

	initial begin
		clk80MHz = 1'b0;
		forever #4 clk80MHz = ~clk80MHz; // 8 ns period
	end

	task automatic failRun(string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "run stopped");
	endtask

	task automatic checkWord(string name, logic [m16Pkg::orbWordW-1:0] exp,
			logic [m16Pkg::orbWordW-1:0] act);
		if (act !== exp) begin
			$display("ERROR %0t ns %s expected %03h actual %03h", $time, name, exp, act);
			failRun("wrong telemetry word");
		end
	endtask

	task automatic checkFlag(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("ERROR %0t ns %s expected %0b actual %0b", $time, name, exp, act);
			failRun("wrong flag value");
		end
	endtask

	task automatic checkGap(string name, int exp, int act);
		if (act != exp) begin
			$display("ERROR %0t ns %s expected %0d actual %0d", $time, name, exp, act);
			failRun("word strobes not evenly spaced");
		end
	endtask

	// word as the packer should build it
	function automatic logic [m16Pkg::orbWordW-1:0] taggedWord(int ch,
			logic [m16Pkg::byteW-1:0] b);
		return {tagW'(ch + 1), b}; // channel number from 1
	endfunction

	function automatic int slotOf(int ch, int idx);
		return 1 + ch * packetBytes + idx; // slot 0 is sync
	endfunction

	// packet bytes land in the bank that is idle while they arrive
	function automatic void loadModel(row_t row, int bank);
		for (int c = 0; c < numChan; c++) begin
			if (row.chanMask[c]) begin
				for (int i = 0; i < packetBytes; i++) begin
					bankImg[bank][slotOf(c, i)] = taggedWord(c, row.bytes[c * packetBytes + i]);
				end
			end
		end
	endfunction

	function automatic void buildTable();
		for (int k = 0; k < numChan * packetBytes; k++) begin
			rows[0].bytes[k] = 8'(8'h11 * (k + 1)); // fixed ramp
			rows[1].bytes[k] = 8'($random(seed));
			rows[2].bytes[k] = 8'(8'hA0 + k);
			rows[3].bytes[k] = 8'($random(seed));
			rows[4].bytes[k] = k[0] ? 8'hFF : 8'h00; // byte extremes
		end
		rows[0].chanMask = 3'b111; // all finish together
		rows[1].chanMask = 3'b111;
		rows[2].chanMask = 3'b010; // other slots keep bank history
		rows[3].chanMask = 3'b101;
		rows[4].chanMask = 3'b001;
	endfunction

	// one 8N1 character, lsb first
	task automatic serialByte(int ch, logic [m16Pkg::byteW-1:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0}; // stop, data, start
		for (int n = 0; n < 10; n++) begin
			@(posedge clk80MHz);
			#driveDly;
			rx[ch] = bits[n];
			repeat (clksPerBit - 1) @(posedge clk80MHz);
		end
	endtask

	task automatic sendPacket(int ch, row_t row);
		for (int i = 0; i < packetBytes; i++) begin
			serialByte(ch, row.bytes[ch * packetBytes + i]);
		end
	endtask

	task automatic sendRow(row_t row);
		for (int c = 0; c < numChan; c++) begin
			automatic int ch = c;
			if (row.chanMask[c]) begin
				fork
					sendPacket(ch, row); // lines run in parallel
				join_none
			end
		end
		wait fork;
	endtask

	// sampled at falling edges, gap counts clocks since the call
	task automatic nextStrobe(output int gap);
		gap = 0;
		do begin
			@(negedge clk80MHz);
			gap++;
			if (frameStart && !wordStrobe) begin
				failRun("frameStart high without wordStrobe");
			end
		end while (!wordStrobe);
	endtask

	// data words of one frame, then the next sync word
	task automatic checkBody(int bank);
		int gap;
		for (int k = 1; k < frameWords; k++) begin
			nextStrobe(gap);
			checkGap("wordStrobe spacing", wordDiv, gap);
			checkFlag("frameStart", 1'b0, frameStart);
			checkWord($sformatf("orbWord[%0d]", k), bankImg[bank][k], orbWord);
		end
		nextStrobe(gap);
		checkGap("wordStrobe spacing", wordDiv, gap);
		checkFlag("frameStart", 1'b1, frameStart); // exactly frameWords strobes
		checkWord("orbWord[0]", m16Pkg::syncWord, orbWord);
	endtask

	initial begin
		cycles = 0;
		while (cycles < timeoutCycles) begin
			@(posedge clk80MHz);
			cycles++;
		end
		failRun($sformatf("timeout after %0d cycles, frames stopped coming", cycles));
	end

	initial begin : mainSeq
		int gap;
		logic sending;
		rstN = 1'b0;
		rx = '1; // lines idle high
		seed = 19;
		buildTable();
		for (int b = 0; b < 2; b++) begin
			for (int k = 0; k < frameWords; k++) begin
				bankImg[b][k] = '0; // cleared by reset sweep
			end
		end
		repeat (16) @(posedge clk80MHz);
		#driveDly;
		rstN = 1'b1;
		@(negedge clk80MHz); // count from the edge that releases reset

		nextStrobe(gap); // quiet until first frame
		checkGap("first wordStrobe after reset", wordDiv, gap);
		checkFlag("frameStart", 1'b1, frameStart);
		checkWord("orbWord[0]", m16Pkg::syncWord, orbWord);

		for (int f = 0; f < numFrames; f++) begin
			sending = (f >= 1) && (f <= numRows); // frame 0 stays empty
			fork
				begin
					if (sending) begin
						sendRow(rows[f - 1]);
					end
				end
				begin
					checkBody(f % 2); // bank read alternates per frame
				end
			join
			if (sending) begin
				loadModel(rows[f - 1], (f + 1) % 2);
			end
		end

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
m16Pkg.sv
uartRx.sv
chanBuffer.sv
rdScheduler.sv
orbPacker.sv
frameBuffer.sv
frameReader.sv
m16Top.sv
tbM16.sv

// File: runSim.sh
#!/usr/bin/env bash
# build and run the telemetry concentrator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tbM16 -f all.f -o simTbM16
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

simOut=$(./obj_dir/simTbM16 2>&1)
status=$?
echo "$simOut"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$simOut" | grep -qx "No errors"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
